/* dv/core_input.txt */
# name drop op postbyte imm pc, then expected a b x y u s dp cc, all numbers hex except drop
# drop 1 offers the command while a NOP keeps the core busy, so nothing may change
ld_a        0 LDA   00 0012 0000 12 00 0000 0000 0000 0000 00 00
ld_b        0 LDB   00 0034 0000 12 34 0000 0000 0000 0000 00 00
ld_d        0 LDD   00 5678 0000 56 78 0000 0000 0000 0000 00 00
ld_x        0 LDX   00 9abc 0000 56 78 9abc 0000 0000 0000 00 00
ld_y        0 LDY   00 def0 0000 56 78 9abc def0 0000 0000 00 00
ld_u        0 LDU   00 0150 0000 56 78 9abc def0 0150 0000 00 00
ld_s        0 LDS   00 01a0 0000 56 78 9abc def0 0150 01a0 00 00
ld_dp       0 LDDP  00 00c3 0000 56 78 9abc def0 0150 01a0 c3 00
adda_h      0 ADDA  00 001a 0000 70 78 9abc def0 0150 01a0 c3 20
adda_vn     0 ADDA  00 0010 0000 80 78 9abc def0 0150 01a0 c3 0a
adda_cz     0 ADDA  00 0080 0000 00 78 9abc def0 0150 01a0 c3 07
ld_d2       0 LDD   00 1000 0000 10 00 9abc def0 0150 01a0 c3 07
subd_pos    0 SUBD  00 0001 0000 0f ff 9abc def0 0150 01a0 c3 00
subd_borrow 0 SUBD  00 8000 0000 8f ff 9abc def0 0150 01a0 c3 0b
subd_zero   0 SUBD  00 8fff 0000 00 00 9abc def0 0150 01a0 c3 04
ld_a3       0 LDA   00 00f0 0000 f0 00 9abc def0 0150 01a0 c3 04
anda_n      0 ANDA  00 009c 0000 90 00 9abc def0 0150 01a0 c3 08
anda_z      0 ANDA  00 000f 0000 00 00 9abc def0 0150 01a0 c3 04
orcc        0 ORCC  00 0051 0000 00 00 9abc def0 0150 01a0 c3 55
andcc       0 ANDCC 00 00af 0000 00 00 9abc def0 0150 01a0 c3 05
ld_d4       0 LDD   00 a55a 0000 a5 5a 9abc def0 0150 01a0 c3 05
tfr_x_y     0 TFR   32 0000 0000 a5 5a 9abc 9abc 0150 01a0 c3 05
tfr_a_x     0 TFR   20 0000 0000 a5 5a 01a5 9abc 0150 01a0 c3 05
tfr_y_b     0 TFR   13 0000 0000 a5 bc 01a5 9abc 0150 01a0 c3 05
exg_a_b     0 EXG   01 0000 0000 bc a5 01a5 9abc 0150 01a0 c3 05
exg_x_y     0 EXG   23 0000 0000 bc a5 9abc 01a5 0150 01a0 c3 05
exg_s_b     0 EXG   41 0000 0000 bc a0 9abc 01a5 0150 01a5 c3 05
drop_lda    1 LDA   00 00ff 0000 bc a0 9abc 01a5 0150 01a5 c3 05
pshs_all    0 PSHS  ff 0000 4321 bc a0 9abc 01a5 0150 0199 c3 05
clr_d       0 LDD   00 0000 0000 00 00 9abc 01a5 0150 0199 c3 05
clr_x       0 LDX   00 0000 0000 00 00 0000 01a5 0150 0199 c3 05
clr_y       0 LDY   00 0000 0000 00 00 0000 0000 0150 0199 c3 05
clr_u       0 LDU   00 0000 0000 00 00 0000 0000 0000 0199 c3 05
clr_dp      0 LDDP  00 0000 0000 00 00 0000 0000 0000 0199 00 05
clr_cc      0 ANDCC 00 0000 0000 00 00 0000 0000 0000 0199 00 00
puls_all    0 PULS  ff 0000 0000 bc a0 9abc 01a5 0150 01a5 c3 05
pshu_part   0 PSHU  56 0000 0000 bc a0 9abc 01a5 014a 01a5 c3 05
ld_s2       0 LDS   00 0000 0000 bc a0 9abc 01a5 014a 0000 c3 05
ld_x2       0 LDX   00 beef 0000 bc a0 beef 01a5 014a 0000 c3 05
ld_d3       0 LDD   00 0000 0000 00 00 beef 01a5 014a 0000 c3 05
pulu_part   0 PULU  56 0000 0000 bc a0 9abc 01a5 0150 01a5 c3 05
drop_pshs   1 PSHS  ff 0000 4321 bc a0 9abc 01a5 0150 01a5 c3 05
pshs_none   0 PSHS  00 0000 0000 bc a0 9abc 01a5 0150 01a5 c3 05

/* dv/kcpu_core_tb.sv */
// kcpu_core testbench that replays a command file and checks registers after each command
`timescale 1ns/1ps

module kcpu_core_tb;

import kcpu_pkg::*;

logic        clk = 1'b0;
logic        rst;
logic        cmd_valid;
kcpu_op_e    cmd_op;
logic [7:0]  postbyte;
logic [15:0] imm;
logic [15:0] pc;
logic        busy;
logic        done;
logic [7:0]  a;
logic [7:0]  b;
logic [15:0] x;
logic [15:0] y;
logic [15:0] u;
logic [15:0] s;
logic [7:0]  dp;
logic [7:0]  cc;

int          mismatches;
int          failures;   // timeouts, file trouble, protocol slips
logic [31:0] lfsr;

kcpu_core i_kcpu_core (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .postbyte  (postbyte),
    .imm       (imm),
    .pc        (pc),
    .busy      (busy),
    .done      (done),
    .a         (a),
    .b         (b),
    .x         (x),
    .y         (y),
    .u         (u),
    .s         (s),
    .dp        (dp),
    .cc        (cc)
);

always #50 clk = ~clk;   // 100 ns period

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] st);
    return {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
endfunction

// command name from the file to the enum value
function automatic kcpu_op_e op_from_name(input string nm, output logic found);
    kcpu_op_e e;
    int       i;
    e = e.first();
    found = 1'b0;
    for (i = 0; i < e.num(); i++) begin
        if (e.name() == nm) begin
            found = 1'b1;
            return e;
        end
        e = e.next();
    end
    return NOP;
endfunction

task automatic check_byte(input string test, input string field,
                          input logic [7:0] expected, input logic [7:0] actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s %s expected %02h actual %02h", test, field, expected, actual);
        mismatches++;
    end
endtask

task automatic check_word(input string test, input string field,
                          input logic [15:0] expected, input logic [15:0] actual);
    if (actual !== expected) begin
        $display("CHECK FAILED %s %s expected %04h actual %04h", test, field, expected, actual);
        mismatches++;
    end
endtask

// 0 to 3 idle cycles from two LFSR bits
task automatic idle_gap();
    logic [1:0] n;
    lfsr = lfsr_next(lfsr);
    n[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    n[1] = lfsr[0];
    repeat (n) @(posedge clk);
endtask

// one-cycle cmd_valid pulse
task automatic issue_command(input kcpu_op_e op_v, input logic [7:0] pb_v,
                             input logic [15:0] imm_v, input logic [15:0] pc_v);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_op    <= op_v;
    postbyte  <= pb_v;
    imm       <= imm_v;
    pc        <= pc_v;
    @(posedge clk);
    cmd_valid <= 1'b0;
endtask

task automatic wait_done(input string test, output logic ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < 200) begin
        @(negedge clk);
        if (done) ok = 1'b1;
        n++;
    end
    if (!ok) begin
        $display("timeout: %s saw no done within 200 cycles", test);
        failures++;
    end
endtask

// a dropped command must not start once the core goes idle
task automatic expect_idle(input string test, input int cycles);
    int   n;
    logic quiet;
    quiet = 1'b1;
    n = 0;
    while (quiet && n < cycles) begin
        @(negedge clk);
        if (busy || done) quiet = 1'b0;
        n++;
    end
    if (!quiet) begin
        $display("%s: core started the command offered while busy", test);
        failures++;
    end
endtask

initial begin
    int          fd;
    int          cnt;
    int          drop;   // offer the command while a NOP holds busy
    logic        alive;
    logic        known;
    string       line;
    string       name;
    string       opname;
    kcpu_op_e    op_v;
    logic [7:0]  pb_v;
    logic [15:0] imm_v;
    logic [15:0] pc_v;
    logic [7:0]  e_a;
    logic [7:0]  e_b;
    logic [15:0] e_x;
    logic [15:0] e_y;
    logic [15:0] e_u;
    logic [15:0] e_s;
    logic [7:0]  e_dp;
    logic [7:0]  e_cc;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd_op     = NOP;
    postbyte   = '0;
    imm        = '0;
    pc         = '0;
    mismatches = 0;
    failures   = 0;
    lfsr       = 32'h48565c4a;
    alive      = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    fd = $fopen("dv/core_input.txt", "r");
    if (fd == 0) begin
        $display("could not open dv/core_input.txt");
        failures++;
    end else begin
        while (alive && !$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (cnt > 0 && line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%s %d %s %h %h %h %h %h %h %h %h %h %h %h",
                              name, drop, opname, pb_v, imm_v, pc_v,
                              e_a, e_b, e_x, e_y, e_u, e_s, e_dp, e_cc);
                op_v = op_from_name(opname, known);
                if (cnt != 14 || !known) begin
                    $display("unreadable stimulus line: %s", line);
                    failures++;
                end else begin
                    idle_gap();
                    if (drop != 0) begin
                        issue_command(NOP, 8'h00, 16'h0000, pc_v);
                        @(negedge clk);
                        if (!busy) begin
                            $display("%s: busy stayed low after a NOP was taken", name);
                            failures++;
                        end
                    end
                    issue_command(op_v, pb_v, imm_v, pc_v);
                    wait_done(name, alive);
                    if (alive && drop != 0) begin
                        expect_idle(name, 8);
                    end
                    if (alive) begin
                        check_byte(name, "a", e_a, a);
                        check_byte(name, "b", e_b, b);
                        check_word(name, "x", e_x, x);
                        check_word(name, "y", e_y, y);
                        check_word(name, "u", e_u, u);
                        check_word(name, "s", e_s, s);
                        check_byte(name, "dp", e_dp, dp);
                        check_byte(name, "cc", e_cc, cc);
                    end
                end
            end
        end
        $fclose(fd);
    end
    $display("errors: %0d value mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
        $display("ALL CHECKS PASSED");
    end else begin
        $display("CHECKS FAILED");
    end
    $finish;
end

endmodule

/* files.f */
verilog/kcpu_pkg.sv
verilog/kcpu_stack_ram.sv
verilog/kcpu_alu.sv
verilog/kcpu_ctrl.sv
verilog/kcpu_regs.sv
verilog/kcpu_core.sv
dv/kcpu_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the kcpu_core testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module kcpu_core_tb -f files.f -o kcpu_core_sim

./obj_dir/kcpu_core_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

/* verilog/kcpu_alu.sv */
// kcpu arithmetic unit, 8/16-bit add, subtract and logic with flag generation
`timescale 1ns/1ps

module kcpu_alu (
    input  kcpu_pkg::kcpu_op_e op,
    input  logic [15:0]        mux_reg0,
    input  logic [15:0]        mux_reg1,
    input  logic [15:0]        mdata,
    input  logic [7:0]         cc,
    output logic [15:0]        alu,
    output logic [7:0]         alu_cc
);

import kcpu_pkg::*;

logic [8:0]  sum8;
logic [16:0] dif16;
logic [7:0]  and8;

always_comb begin
    sum8   = {1'b0, mux_reg0[7:0]} + {1'b0, mux_reg1[7:0]};
    dif16  = {1'b0, mux_reg0} - {1'b0, mux_reg1};
    and8   = mux_reg0[7:0] & mux_reg1[7:0];
    alu    = mdata;   // loads go straight through
    alu_cc = cc;
    case (op)
        ADDA: begin
            alu          = {8'h00, sum8[7:0]};
            alu_cc[CC_H] = mux_reg0[4] ^ mux_reg1[4] ^ sum8[4];
            alu_cc[CC_N] = sum8[7];
            alu_cc[CC_Z] = sum8[7:0] == 8'h00;
            alu_cc[CC_V] = (mux_reg0[7] == mux_reg1[7]) && (sum8[7] != mux_reg0[7]);
            alu_cc[CC_C] = sum8[8];
        end
        SUBD: begin
            alu          = dif16[15:0];
            alu_cc[CC_N] = dif16[15];
            alu_cc[CC_Z] = dif16[15:0] == 16'h0000;
            alu_cc[CC_V] = (mux_reg0[15] != mux_reg1[15]) && (dif16[15] != mux_reg0[15]);
            alu_cc[CC_C] = dif16[16];   // borrow
        end
        ANDA: begin
            alu          = {8'h00, and8};
            alu_cc[CC_N] = and8[7];
            alu_cc[CC_Z] = and8 == 8'h00;
            alu_cc[CC_V] = 1'b0;
        end
        ANDCC: alu_cc = and8;
        ORCC:  alu_cc = mux_reg0[7:0] | mux_reg1[7:0];
        default: ;
    endcase
end

endmodule

/* verilog/kcpu_core.sv */
// kcpu register and stack datapath top, sequencer, register file, ALU and stack memory
`timescale 1ns/1ps

module kcpu_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_valid,
    input  kcpu_pkg::kcpu_op_e cmd_op,
    input  logic [7:0]         postbyte,
    input  logic [15:0]        imm,
    input  logic [15:0]        pc,
    output logic               busy,
    output logic               done,
    output logic [7:0]         a,
    output logic [7:0]         b,
    output logic [15:0]        x,
    output logic [15:0]        y,
    output logic [15:0]        u,
    output logic [15:0]        s,
    output logic [7:0]         dp,
    output logic [7:0]         cc
);

import kcpu_pkg::*;

kcpu_op_e    op;
logic [15:0] mdata;
logic [15:0] mux_reg0;
logic [15:0] mux_reg1;
logic [15:0] psh_addr;
logic [15:0] alu;
logic [7:0]  alu_cc;
logic [7:0]  psh_sel;
logic [7:0]  psh_mux;
logic [7:0]  stack_bit;
logic [7:0]  rdata;
logic        we;
logic        psh_hihalf;
logic        psh_ussel;
logic        psh_dec;
logic        pul_en;
logic        up_a;
logic        up_b;
logic        up_d;
logic        up_x;
logic        up_y;
logic        up_u;
logic        up_s;
logic        up_dp;
logic        up_cc;
logic        up_tfr;
logic        up_exg;

kcpu_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .postbyte   (postbyte),
    .imm        (imm),
    .stack_bit  (stack_bit),
    .rdata      (rdata),
    .op         (op),
    .mdata      (mdata),
    .busy       (busy),
    .done       (done),
    .we         (we),
    .psh_sel    (psh_sel),
    .psh_hihalf (psh_hihalf),
    .psh_ussel  (psh_ussel),
    .psh_dec    (psh_dec),
    .pul_en     (pul_en),
    .up_a       (up_a),
    .up_b       (up_b),
    .up_d       (up_d),
    .up_x       (up_x),
    .up_y       (up_y),
    .up_u       (up_u),
    .up_s       (up_s),
    .up_dp      (up_dp),
    .up_cc      (up_cc),
    .up_tfr     (up_tfr),
    .up_exg     (up_exg)
);

// pulled pc bytes have no destination here
kcpu_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .mdata      (mdata),
    .op         (op),
    .up_a       (up_a),
    .up_b       (up_b),
    .up_d       (up_d),
    .up_x       (up_x),
    .up_y       (up_y),
    .up_u       (up_u),
    .up_s       (up_s),
    .up_dp      (up_dp),
    .up_cc      (up_cc),
    .up_tfr     (up_tfr),
    .up_exg     (up_exg),
    .psh_sel    (psh_sel),
    .psh_hihalf (psh_hihalf),
    .psh_ussel  (psh_ussel),
    .psh_dec    (psh_dec),
    .pul_en     (pul_en),
    .alu        (alu),
    .alu_cc     (alu_cc),
    .mux_reg0   (mux_reg0),
    .mux_reg1   (mux_reg1),
    .psh_mux    (psh_mux),
    .psh_addr   (psh_addr),
    .stack_bit  (stack_bit),
    .up_pul_pc  (),
    .a          (a),
    .b          (b),
    .x          (x),
    .y          (y),
    .u          (u),
    .s          (s),
    .dp         (dp),
    .cc         (cc)
);

kcpu_alu u_alu (
    .op       (op),
    .mux_reg0 (mux_reg0),
    .mux_reg1 (mux_reg1),
    .mdata    (mdata),
    .cc       (cc),
    .alu      (alu),
    .alu_cc   (alu_cc)
);

kcpu_stack_ram #(
    .AW (RAM_AW)
) u_stack_ram (
    .clk   (clk),
    .we    (we),
    .addr  (psh_addr[RAM_AW-1:0]),
    .wdata (psh_mux),
    .rdata (rdata)
);

endmodule

/* verilog/kcpu_ctrl.sv */
// kcpu command sequencer, turns one command into register strobes and stack byte steps
`timescale 1ns/1ps

module kcpu_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_valid,
    input  kcpu_pkg::kcpu_op_e cmd_op,
    input  logic [7:0]         postbyte,
    input  logic [15:0]        imm,
    input  logic [7:0]         stack_bit,
    input  logic [7:0]         rdata,
    output kcpu_pkg::kcpu_op_e op,
    output logic [15:0]        mdata,
    output logic               busy,
    output logic               done,
    output logic               we,
    output logic [7:0]         psh_sel,
    output logic               psh_hihalf,
    output logic               psh_ussel,
    output logic               psh_dec,
    output logic               pul_en,
    output logic               up_a,
    output logic               up_b,
    output logic               up_d,
    output logic               up_x,
    output logic               up_y,
    output logic               up_u,
    output logic               up_s,
    output logic               up_dp,
    output logic               up_cc,
    output logic               up_tfr,
    output logic               up_exg
);

import kcpu_pkg::*;

typedef enum logic [3:0] {
    IDLE,
    OPER,
    WRITE,
    PSH_SEL,
    PSH_DEC,
    PSH_WR,
    PUL_RD,
    PUL_WR,
    FINISH
} state_e;

state_e      state;
logic [15:0] imm_r;
logic        half;       // working on the second byte of a 16-bit register
logic        stk_op;
logic        pul_op;
logic        is16;
logic        wr;
logic [7:0]  sel_left;

assign stk_op   = op inside {PSHS, PULS, PSHU, PULU};
assign pul_op   = op == PULS || op == PULU;
assign is16     = |stack_bit[7:4];   // pc, other sp, y, x
assign sel_left = psh_sel & ~stack_bit;

assign psh_ussel  = op == PSHU || op == PULU;
assign psh_hihalf = pul_op ? is16 && !half : half;   // pulls take the high byte first
assign psh_dec    = state == PSH_DEC;
assign we         = state == PSH_WR;
assign pul_en     = state == PUL_WR;

// postbyte doubles as the TFR/EXG register select
assign mdata = pul_en ? {8'h00, rdata} :
               (op == TFR || op == EXG) ? {8'h00, psh_sel} : imm_r;

assign wr     = state == WRITE;
assign up_a   = wr && (op == LDA || op == ADDA || op == ANDA);
assign up_b   = wr && op == LDB;
assign up_d   = wr && (op == LDD || op == SUBD);
assign up_x   = wr && op == LDX;
assign up_y   = wr && op == LDY;
assign up_u   = wr && op == LDU;
assign up_s   = wr && op == LDS;
assign up_dp  = wr && op == LDDP;
assign up_cc  = wr && op inside {ADDA, SUBD, ANDA, ANDCC, ORCC};
assign up_tfr = wr && op == TFR;
assign up_exg = wr && op == EXG;

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        state   <= IDLE;
        op      <= NOP;
        imm_r   <= '0;
        psh_sel <= '0;
        half    <= 1'b0;
        busy    <= 1'b0;
        done    <= 1'b0;
    end else begin
        done <= 1'b0;
        case (state)
            IDLE: begin
                if (cmd_valid) begin
                    op      <= cmd_op;
                    imm_r   <= imm;
                    psh_sel <= postbyte;
                    busy    <= 1'b1;
                    state   <= OPER;
                end
            end
            OPER: begin
                half <= 1'b0;
                if (!stk_op) begin
                    state <= WRITE;
                end else if (psh_sel == 8'h00) begin
                    state <= FINISH;   // nothing to move
                end else begin
                    state <= pul_op ? PUL_RD : PSH_SEL;
                end
            end
            PSH_SEL: state <= PSH_DEC;
            PSH_DEC: state <= PSH_WR;
            PUL_RD:  state <= PUL_WR;
            PSH_WR, PUL_WR: begin
                if (is16 && !half) begin
                    half  <= 1'b1;   // same register, other byte
                    state <= pul_op ? PUL_RD : PSH_SEL;
                end else begin
                    half    <= 1'b0;
                    psh_sel <= sel_left;
                    if (sel_left == 8'h00) begin
                        state <= FINISH;
                    end else begin
                        state <= pul_op ? PUL_RD : PSH_SEL;
                    end
                end
            end
            WRITE, FINISH: begin
                busy  <= 1'b0;
                done  <= 1'b1;
                state <= IDLE;
            end
            default: state <= IDLE;
        endcase
    end
end

endmodule

/* verilog/kcpu_pkg.sv */
// kcpu shared definitions: command codes, flag positions, transfer register codes
package kcpu_pkg;

// commands accepted by the sequencer
typedef enum logic [4:0] {
    NOP,
    LDA,
    LDB,
    LDD,
    LDX,
    LDY,
    LDU,
    LDS,
    LDDP,
    ADDA,
    SUBD,
    ANDA,
    ANDCC,
    ORCC,
    TFR,
    EXG,
    PSHS,
    PULS,
    PSHU,
    PULU
} kcpu_op_e;

// condition code bits, 6809 layout
localparam logic [2:0] CC_C = 3'd0;
localparam logic [2:0] CC_V = 3'd1;
localparam logic [2:0] CC_Z = 3'd2;
localparam logic [2:0] CC_N = 3'd3;
localparam logic [2:0] CC_I = 3'd4;
localparam logic [2:0] CC_H = 3'd5;
localparam logic [2:0] CC_F = 3'd6;
localparam logic [2:0] CC_E = 3'd7;

// register codes in the TFR/EXG postbyte fields
typedef enum logic [2:0] {
    REG_A    = 3'd0,
    REG_B    = 3'd1,
    REG_X    = 3'd2,
    REG_Y    = 3'd3,
    REG_S    = 3'd4,
    REG_U    = 3'd5,
    REG_INV6 = 3'd6,
    REG_INV7 = 3'd7
} kcpu_tfr_e;

localparam int RAM_AW = 8;   // stack memory address bits

endpackage

/* verilog/kcpu_regs.sv */
// kcpu register file with stack pointer update, TFR/EXG and push/pull byte steering
`timescale 1ns/1ps

module kcpu_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic [15:0]        pc,
    input  logic [15:0]        mdata,   // load data, pulled byte or postbyte
    input  kcpu_pkg::kcpu_op_e op,
    input  logic               up_a,
    input  logic               up_b,
    input  logic               up_d,
    input  logic               up_x,
    input  logic               up_y,
    input  logic               up_u,
    input  logic               up_s,
    input  logic               up_dp,
    input  logic               up_cc,
    input  logic               up_tfr,
    input  logic               up_exg,
    input  logic [7:0]         psh_sel,
    input  logic               psh_hihalf,
    input  logic               psh_ussel,
    input  logic               psh_dec,
    input  logic               pul_en,
    input  logic [15:0]        alu,
    input  logic [7:0]         alu_cc,
    output logic [15:0]        mux_reg0,
    output logic [15:0]        mux_reg1,
    output logic [7:0]         psh_mux,
    output logic [15:0]        psh_addr,
    output logic [7:0]         stack_bit,
    output logic               up_pul_pc,
    output logic [7:0]         a,
    output logic [7:0]         b,
    output logic [15:0]        x,
    output logic [15:0]        y,
    output logic [15:0]        u,
    output logic [15:0]        s,
    output logic [7:0]         dp,
    output logic [7:0]         cc
);

import kcpu_pkg::*;

logic [7:0]  psh_bit;
logic [7:0]  pul_bit;
logic [15:0] d;
logic [15:0] psh_other;
logic [15:0] stfr;
logic [15:0] dtfr;
logic [15:0] nx_u;
logic [15:0] nx_s;
logic        pul_other;
kcpu_tfr_e   dsel;
kcpu_tfr_e   ssel;

// 8-bit sources keep the high byte of u
function automatic logic [15:0] tfr_read(input kcpu_tfr_e sel);
    logic [15:0] val;
    val = u;
    case (sel)
        REG_A:   val[7:0] = a;
        REG_B:   val[7:0] = b;
        REG_X:   val = x;
        REG_Y:   val = y;
        REG_S:   val = s;
        REG_U:   val = u;
        default: ;
    endcase
    return val;
endfunction

// merge one pulled byte into a 16-bit register
function automatic logic [15:0] pul_word(input logic [15:0] cur);
    return psh_hihalf ? {mdata[7:0], cur[7:0]} : {cur[15:8], mdata[7:0]};
endfunction

assign d         = {a, b};
assign psh_addr  = psh_ussel ? u : s;
assign psh_other = psh_ussel ? s : u;
assign stack_bit = pul_en ? pul_bit : psh_bit;
assign up_pul_pc = pul_en && pul_bit[7];
assign pul_other = pul_en && pul_bit[6];
assign dsel      = kcpu_tfr_e'(mdata[6:4]);
assign ssel      = kcpu_tfr_e'(mdata[2:0]);
assign mux_reg1  = op == SUBD ? mdata : {8'h00, mdata[7:0]};   // immediate operand

always_comb begin
    stfr = tfr_read(ssel);
    dtfr = tfr_read(dsel);
end

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        mux_reg0 <= '0;
    end else begin
        case (op)
            SUBD:        mux_reg0 <= d;
            ANDCC, ORCC: mux_reg0 <= {8'h00, cc};
            default:     mux_reg0 <= {8'h00, a};
        endcase
    end
end

// next u and s
always_comb begin
    nx_u = u;
    nx_s = s;
    if (up_u) nx_u = mdata;
    if (up_s) nx_s = mdata;
    if (psh_dec) begin
        if (psh_ussel) nx_u = u - 16'd1;
        else nx_s = s - 16'd1;
    end
    if (pul_other && psh_ussel) nx_s = pul_word(s);
    if (pul_other && !psh_ussel) nx_u = pul_word(u);
    if (pul_en) begin   // step past the byte just read
        if (psh_ussel) nx_u = u + 16'd1;
        else nx_s = s + 16'd1;
    end
end

// push takes the highest mask bit, pull the lowest
always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        psh_mux <= '0;
        psh_bit <= '0;
        pul_bit <= '0;
    end else begin
        pul_bit <= psh_sel & (~psh_sel + 8'd1);
        casez (psh_sel)
            8'b1???_????: psh_mux <= psh_hihalf ? pc[15:8] : pc[7:0];
            8'b01??_????: psh_mux <= psh_hihalf ? psh_other[15:8] : psh_other[7:0];
            8'b001?_????: psh_mux <= psh_hihalf ? y[15:8] : y[7:0];
            8'b0001_????: psh_mux <= psh_hihalf ? x[15:8] : x[7:0];
            8'b0000_1???: psh_mux <= dp;
            8'b0000_01??: psh_mux <= b;
            8'b0000_001?: psh_mux <= a;
            default:      psh_mux <= cc;
        endcase
        casez (psh_sel)
            8'b1???_????: psh_bit <= 8'h80;
            8'b01??_????: psh_bit <= 8'h40;
            8'b001?_????: psh_bit <= 8'h20;
            8'b0001_????: psh_bit <= 8'h10;
            8'b0000_1???: psh_bit <= 8'h08;
            8'b0000_01??: psh_bit <= 8'h04;
            8'b0000_001?: psh_bit <= 8'h02;
            default:      psh_bit <= {7'd0, psh_sel[0]};
        endcase
    end
end

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        a  <= '0;
        b  <= '0;
        x  <= '0;
        y  <= '0;
        u  <= '0;
        s  <= '0;
        dp <= '0;
        cc <= '0;
    end else begin
        u <= nx_u;
        s <= nx_s;
        if (up_a) a <= alu[7:0];
        if (up_b) b <= alu[7:0];
        if (up_d) begin
            a <= alu[15:8];
            b <= alu[7:0];
        end
        if (up_x) x <= mdata;
        if (up_y) y <= mdata;
        if (up_dp) dp <= alu[7:0];
        if (up_cc) cc <= alu_cc;
        if (pul_en) begin
            if (pul_bit[0]) cc <= mdata[7:0];
            if (pul_bit[1]) a <= mdata[7:0];
            if (pul_bit[2]) b <= mdata[7:0];
            if (pul_bit[3]) dp <= mdata[7:0];
            if (pul_bit[4]) x <= pul_word(x);
            if (pul_bit[5]) y <= pul_word(y);
        end
        // destination field gets the source
        if (up_tfr || up_exg) begin
            case (dsel)
                REG_A:   a <= stfr[7:0];
                REG_B:   b <= stfr[7:0];
                REG_X:   x <= stfr;
                REG_Y:   y <= stfr;
                REG_S:   s <= stfr;
                REG_U:   u <= stfr;
                default: ;
            endcase
        end
        if (up_exg) begin   // and the other way round
            case (ssel)
                REG_A:   a <= dtfr[7:0];
                REG_B:   b <= dtfr[7:0];
                REG_X:   x <= dtfr;
                REG_Y:   y <= dtfr;
                REG_S:   s <= dtfr;
                REG_U:   u <= dtfr;
                default: ;
            endcase
        end
    end
end

endmodule

/* verilog/kcpu_stack_ram.sv */
// kcpu stack memory, byte wide, synchronous write and registered read
`timescale 1ns/1ps

module kcpu_stack_ram #(
    parameter int AW = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] addr,
    input  logic [7:0]    wdata,
    output logic [7:0]    rdata
);

logic [7:0] mem [2**AW];

always_ff @(posedge clk) begin
    if (we) begin
        mem[addr] <= wdata;
    end
    rdata <= mem[addr];   // old data on a same-cycle write
end

endmodule
